// File: files.f
gem_link_pkg.sv
startup_pkg.sv
startup_sequencer.sv
link_ready_timer.sv
link_framer.sv
gem_data_out_top.sv
tb_clock_gen.sv
gem_data_out_asserts.sv
gem_data_out_tb.sv

// File: Bender.yml
package:
  name: gem_data_out

sources:
  - files:
      - gem_link_pkg.sv
      - startup_pkg.sv
      - startup_sequencer.sv
      - link_ready_timer.sv
      - link_framer.sv
      - gem_data_out_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - gem_data_out_asserts.sv
      - gem_data_out_tb.sv

// File: gem_data_out_tb.sv
`timescale 1ns/10ps

module gem_data_out_tb;

   import gem_link_pkg::*;

   localparam int n_links        = 2;
   localparam int mgt_reset_step = 8;
   localparam int txreset_cnt    = 40;
   localparam int done_cnt       = 60;
   localparam int ready_cnt_max  = 20;
   localparam int cnt_max        = 2**22 - 1;   // Startup counter saturation

   typedef enum {reset_done, links_released, startup_up, startup_down, pcs_pulse} wait_cond_t;

   logic                           clock_40;
   logic                           reset_i;
   logic [n_links*link_data_w-1:0] gem_data_i;
   logic                           overflow_i;
   logic [11:0]                    bxn_counter_i;
   logic                           bc0_i;
   logic                           resync_i;
   logic                           tx_done_i;
   logic                           force_not_ready_i;
   logic [n_links-1:0]             mgt_reset_i;
   logic                           txreset_i;
   logic [n_links*tx_word_w-1:0]   tx_data_o;
   logic [n_links*2-1:0]           tx_isk_o;
   logic [n_links-1:0]             mgt_reset_o;
   logic                           txreset_o;
   logic                           startup_done_o;
   logic                           ready_o;

   integer      seed = 32'h2e9a;
   int          m_cnt;                   // Model startup count
   int          m_run;                   // Cycles out of ready hold
   int          m_word;                  // Model frame word index
   logic        m_link_up;
   logic [17:0] m_frame [n_links];       // Expected {isk, word} per link
   bit          model_valid = 1'b0;
   bit          retry;

   tb_clock_gen #(.period(40), .reset_cycles(16)) tb_clock_gen_i (
      .clock_40 (clock_40),
      .reset_o  (reset_i)
   );

   gem_data_out_top #(
      .n_links(n_links), .mgt_reset_step(mgt_reset_step), .txreset_cnt(txreset_cnt),
      .done_cnt(done_cnt), .allow_retry(1'b1), .ready_cnt_max(ready_cnt_max),
      .allow_ttc_chars(1'b1)
   ) gem_data_out_top_i (.*);

   bind gem_data_out_top gem_data_out_asserts #(.n_links(n_links)) asserts_i (
      .clock_40(clock_40), .reset_i(reset_i), .manual_txreset_i(txreset_i),
      .pcs_reset_i(txreset_o), .tx_data_i(tx_data_o), .tx_isk_i(tx_isk_o)
   );

   // ------------------------------------------------------------
   // Reference functions
   // ------------------------------------------------------------

   // {startup_done, txreset, mgt_reset} for a given startup count
   function automatic logic [n_links+1:0] startup_ref(input int cnt);
      logic [n_links+1:0] r;
      r[n_links+1] = cnt > done_cnt;
      r[n_links]   = cnt == txreset_cnt;             // One-cycle PCS reset
      for (int k = 0; k < n_links; k++)
         r[k] = cnt < mgt_reset_step * (k + 1);      // Staggered release
      return r;
   endfunction

   // Word index -1 means link down
   function automatic logic [17:0] frame_ref(input logic [55:0] d, input logic bc0,
                                             input logic resync, input logic ovf,
                                             input logic [1:0] bx, input int idx);
      logic [7:0] sep;
      if (bc0) sep = 8'h1C;
      else if (resync) sep = 8'h3C;
      else if (ovf) sep = 8'hFE;
      else sep = bx[1] ? (bx[0] ? 8'hFD : 8'hFB) : (bx[0] ? 8'hF7 : 8'hBC);
      case (idx)
         0:       return {2'b01, d[7:0], sep};
         1:       return {2'b00, d[23:8]};
         2:       return {2'b00, d[39:24]};
         3:       return {2'b00, d[55:40]};
         default: return {2'b01, 16'hFFFC};           // Idle comma
      endcase
   endfunction

   // ------------------------------------------------------------
   // Checks and waits
   // ------------------------------------------------------------

   task automatic compare_value(input string what, input logic [31:0] actual,
                                input logic [31:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   function automatic bit cond_met(input wait_cond_t c);
      case (c)
         reset_done:     return !reset_i;
         links_released: return mgt_reset_o == '0;
         startup_up:     return startup_done_o;
         startup_down:   return !startup_done_o;
         default:        return txreset_o;
      endcase
   endfunction

   // Polls on the falling edge where outputs are settled
   task automatic wait_until(input wait_cond_t c, input int limit);
      int n;
      n = 0;
      do begin
         @(negedge clock_40);
         n++;
         if (n > limit) begin
            $display("timed out after %0d cycles waiting for %s", limit, c.name());
            $display("ERRORS FOUND");
            $fatal(1);
         end
      end while (!cond_met(c));
   endtask

   // New data and TTC flags for one frame
   task automatic drive_frame_inputs();
      logic [127:0] r;
      logic [31:0]  flags;
      r = {$random(seed), $random(seed), $random(seed), $random(seed)};
      flags = $random(seed);
      gem_data_i    <= r[n_links*link_data_w-1:0];
      bc0_i         <= flags[0] & flags[1];       // Rare, so lower priorities show up
      resync_i      <= flags[2] & flags[3];
      overflow_i    <= flags[4];
      bxn_counter_i <= flags[19:8];
   endtask

   // ------------------------------------------------------------
   // Cycle model and comparison
   // ------------------------------------------------------------

   always @(posedge clock_40) begin
      retry = (m_cnt > done_cnt) && !m_link_up;   // Link lost after startup
      for (int k = 0; k < n_links; k++)
         m_frame[k] = frame_ref(gem_data_i[k*link_data_w +: link_data_w], bc0_i, resync_i,
                                overflow_i, bxn_counter_i[1:0],
                                (reset_i || !m_link_up) ? -1 : m_word);
      m_word = (reset_i || !m_link_up) ? 0 : (m_word + 1) % 4;
      if (reset_i || retry) m_cnt = 0;
      else if (m_cnt < cnt_max) m_cnt++;
      if (reset_i || !m_link_up || force_not_ready_i) m_run = 0;
      else if (m_run <= ready_cnt_max) m_run++;  // Ready once past the hold-off
      m_link_up   = reset_i ? 1'b0 : tx_done_i;
      model_valid = 1'b1;
   end

   always @(negedge clock_40) begin
      if (model_valid) begin
         compare_value("startup outputs", {startup_done_o, txreset_o, mgt_reset_o},
                       startup_ref(m_cnt));
         compare_value("ready_o", ready_o, m_run > ready_cnt_max);
         for (int k = 0; k < n_links; k++)
            compare_value($sformatf("link %0d isk and word", k),
                          {tx_isk_o[2*k +: 2], tx_data_o[tx_word_w*k +: tx_word_w]}, m_frame[k]);
         compare_value("assertion failures", gem_data_out_top_i.asserts_i.fail_cnt, 0);
      end
   end

   // ------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------

   initial begin
      gem_data_i        = '0;
      overflow_i        = 1'b0;
      bxn_counter_i     = '0;
      bc0_i             = 1'b0;
      resync_i          = 1'b0;
      tx_done_i         = 1'b0;
      force_not_ready_i = 1'b0;
      mgt_reset_i       = '0;
      txreset_i         = 1'b0;
      wait_until(reset_done, 40);
      wait_until(links_released, 40);             // Idle words checked meanwhile
      @(posedge clock_40);
      tx_done_i <= 1'b1;
      @(posedge clock_40);                        // Align to the first frame
      for (int f = 0; f < 26; f++) begin
         drive_frame_inputs();
         force_not_ready_i <= (f == 12) || (f == 13);   // Drop ready for two frames
         repeat (4) @(posedge clock_40);
      end
      wait_until(startup_up, 100);
      @(posedge clock_40);
      tx_done_i <= 1'b0;                          // Link lost, sequence restarts
      wait_until(startup_down, 10);
      wait_until(links_released, 40);
      wait_until(pcs_pulse, 100);
      wait_until(startup_up, 100);
      @(posedge clock_40);
      $display("NO ERRORS");
      $finish;
   end

endmodule

// File: gem_data_out_asserts.sv
`timescale 1ns/10ps

module gem_data_out_asserts #(
   parameter int n_links = 2
) (
   input logic                                       clock_40,
   input logic                                       reset_i,
   input logic                                       manual_txreset_i,  // Holds PCS reset
   input logic                                       pcs_reset_i,       // DUT txreset_o
   input logic [n_links*gem_link_pkg::tx_word_w-1:0] tx_data_i,
   input logic [n_links*2-1:0]                       tx_isk_i
);

   import gem_link_pkg::*;

   int unsigned fail_cnt = 0;   // Failed assertions so far

   // Low byte of a separator or of the idle word
   function automatic bit comma_byte(input logic [7:0] b);
      return b inside {k28_0, k28_1, k30_7, k28_5, k23_7, k27_7, k29_7, idle_word[7:0]};
   endfunction

   // ------------------------------------------------------------
   // Startup PCS reset
   // ------------------------------------------------------------

   pcs_reset_single: assert property (@(posedge clock_40)
      disable iff (reset_i || manual_txreset_i) pcs_reset_i |=> !pcs_reset_i)
      else begin
         fail_cnt++;
         $error("txreset_o stayed high for more than one cycle");
      end

   // ------------------------------------------------------------
   // Per-link K flags
   // ------------------------------------------------------------

   for (genvar k = 0; k < n_links; k++) begin : link_chk
      isk_on_comma: assert property (@(posedge clock_40) disable iff (reset_i)
         (tx_isk_i[2*k +: 2] == 2'b01) |-> comma_byte(tx_data_i[tx_word_w*k +: 8]))
         else begin
            fail_cnt++;
            $error("link %0d flags a K-code on a non-separator word", k);
         end
   end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int period       = 40,   // ns
   parameter int reset_cycles = 16
) (
   output logic clock_40,
   output logic reset_o
);

   initial begin
      clock_40 = 1'b0;
      forever #(period / 2) clock_40 = ~clock_40;
   end

   // Reset seen by the first reset_cycles rising edges
   initial begin
      reset_o = 1'b1;
      repeat (reset_cycles) @(posedge clock_40);
      reset_o <= 1'b0;
   end

endmodule

// File: gem_data_out_top.sv
`timescale 1ns/10ps

module gem_data_out_top #(
   parameter int n_links         = 2,
   parameter int mgt_reset_step  = startup_pkg::default_mgt_reset_step,
   parameter int txreset_cnt     = startup_pkg::default_txreset_cnt,
   parameter int done_cnt        = startup_pkg::default_done_cnt,
   parameter bit allow_retry     = 1'b0,
   parameter int ready_cnt_max   = 262143,
   parameter bit allow_ttc_chars = 1'b1
) (
   input  logic                                         clock_40,
   input  logic                                         reset_i,
   input  logic [n_links*gem_link_pkg::link_data_w-1:0] gem_data_i,  // Link k at 56k
   input  logic                                         overflow_i,
   input  logic [11:0]                                  bxn_counter_i,
   input  logic                                         bc0_i,
   input  logic                                         resync_i,
   input  logic                                         tx_done_i,
   input  logic                                         force_not_ready_i,
   input  logic [n_links-1:0]                           mgt_reset_i,
   input  logic                                         txreset_i,
   output logic [n_links*gem_link_pkg::tx_word_w-1:0]   tx_data_o,
   output logic [n_links*2-1:0]                         tx_isk_o,
   output logic [n_links-1:0]                           mgt_reset_o,
   output logic                                         txreset_o,
   output logic                                         startup_done_o,
   output logic                                         ready_o
);

   import gem_link_pkg::*;

   logic link_up;        // Registered transceiver done
   logic startup_done;

   // ------------------------------------------------------------
   // Startup and link readiness
   // ------------------------------------------------------------

   startup_sequencer #(
      .n_links        (n_links),
      .mgt_reset_step (mgt_reset_step),
      .txreset_cnt    (txreset_cnt),
      .done_cnt       (done_cnt),
      .allow_retry    (allow_retry)
   ) startup_sequencer_i (
      .clock_40       (clock_40),
      .reset_i        (reset_i),
      .link_up_i      (link_up),
      .mgt_reset_i    (mgt_reset_i),
      .txreset_i      (txreset_i),
      .mgt_reset_o    (mgt_reset_o),
      .txreset_o      (txreset_o),
      .startup_done_o (startup_done)
   );

   assign startup_done_o = startup_done;

   link_ready_timer #(
      .ready_cnt_max     (ready_cnt_max)
   ) link_ready_timer_i (
      .clock_40          (clock_40),
      .reset_i           (reset_i),
      .tx_done_i         (tx_done_i),
      .force_not_ready_i (force_not_ready_i),
      .link_up_o         (link_up),
      .ready_o           (ready_o)
   );

   // ------------------------------------------------------------
   // One framer per link, TTC flags shared
   // ------------------------------------------------------------

   for (genvar k = 0; k < n_links; k++) begin : link_gen
      link_framer #(
         .allow_ttc_chars (allow_ttc_chars)
      ) link_framer_i (
         .clock_40    (clock_40),
         .reset_i     (reset_i),
         .link_up_i   (link_up),
         .link_data_i (gem_data_i[k*link_data_w +: link_data_w]),
         .bc0_i       (bc0_i),
         .resync_i    (resync_i),
         .overflow_i  (overflow_i),
         .bxn_lsbs_i  (bxn_counter_i[1:0]),   // Rotation follows the bunch counter
         .tx_data_o   (tx_data_o[k*tx_word_w +: tx_word_w]),
         .tx_isk_o    (tx_isk_o[k*2 +: 2])
      );
   end

endmodule

// File: link_framer.sv
`timescale 1ns/10ps

module link_framer #(
   parameter bit allow_ttc_chars = 1'b1   // Enables BC0, resync and overflow codes
) (
   input  logic                               clock_40,
   input  logic                               reset_i,
   input  logic                               link_up_i,
   input  logic [gem_link_pkg::link_data_w-1:0] link_data_i,   // This link's GEM half-word
   input  logic                               bc0_i,
   input  logic                               resync_i,
   input  logic                               overflow_i,    // More than 8 clusters
   input  logic [1:0]                         bxn_lsbs_i,    // Bunch counter bits 1:0
   output logic [gem_link_pkg::tx_word_w-1:0]   tx_data_o,
   output logic [1:0]                         tx_isk_o
);

   import gem_link_pkg::*;

   frame_word_t frame_cnt;   // Word being built this cycle
   kcode_t      frame_sep;   // Separator for the current frame

   // ------------------------------------------------------------
   // Frame word counter
   // ------------------------------------------------------------

   // Starts at word_sep in the first link-up cycle, then 0,1,2,3 and wraps
   always_ff @(posedge clock_40) begin
      if (reset_i || !link_up_i) begin
         frame_cnt <= word_sep;
      end else begin
         frame_cnt <= frame_word_t'(frame_cnt + 2'd1);   // Wraps at word_3
      end
   end

   // ------------------------------------------------------------
   // Separator choice
   // ------------------------------------------------------------

   always_comb begin
      if (allow_ttc_chars && bc0_i) begin
         frame_sep = k28_0;                  // BC0 wins over everything
      end else if (allow_ttc_chars && resync_i) begin
         frame_sep = k28_1;
      end else if (allow_ttc_chars && overflow_i) begin
         frame_sep = k30_7;
      end else begin
         // Bunch sequence marker, four-code rotation
         case (bxn_lsbs_i)
            2'd0:    frame_sep = k28_5;
            2'd1:    frame_sep = k23_7;
            2'd2:    frame_sep = k27_7;
            default: frame_sep = k29_7;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Registered word output
   // ------------------------------------------------------------

   always_ff @(posedge clock_40) begin
      if (reset_i || !link_up_i) begin
         tx_data_o <= idle_word;   // Comma idle while link is down
         tx_isk_o  <= 2'b01;
      end else begin
         case (frame_cnt)
            word_sep: begin
               tx_data_o <= {link_data_i[7:0], frame_sep};   // K-code in low byte
               tx_isk_o  <= 2'b01;
            end
            word_1: begin
               tx_data_o <= link_data_i[23:8];
               tx_isk_o  <= 2'b00;
            end
            word_2: begin
               tx_data_o <= link_data_i[39:24];
               tx_isk_o  <= 2'b00;
            end
            default: begin                                   // word_3
               tx_data_o <= link_data_i[55:40];
               tx_isk_o  <= 2'b00;
            end
         endcase
      end
   end

endmodule

// File: link_ready_timer.sv
`timescale 1ns/10ps

module link_ready_timer #(
   parameter int ready_cnt_max = 262143   // Hold-off in clock_40 cycles
) (
   input  logic clock_40,
   input  logic reset_i,
   input  logic tx_done_i,          // Transceiver reset FSM done
   input  logic force_not_ready_i,  // Drops ready on the next edge
   output logic link_up_o,
   output logic ready_o
);

   localparam int ready_w = $clog2(ready_cnt_max + 1);
   localparam logic [ready_w-1:0] ready_max = ready_w'(ready_cnt_max);

   logic               link_up;
   logic               hold;         // Timer cleared this cycle
   logic               timer_armed;  // Set one cycle after hold ends
   logic [ready_w-1:0] ready_cnt;

   // ------------------------------------------------------------
   // Link-up register
   // ------------------------------------------------------------

   always_ff @(posedge clock_40) begin
      if (reset_i) begin
         link_up <= 1'b0;
      end else begin
         link_up <= tx_done_i;   // One cycle behind the transceiver
      end
   end

   assign link_up_o = link_up;

   // ------------------------------------------------------------
   // Ready hold-off timer
   // ------------------------------------------------------------

   assign hold = !link_up || force_not_ready_i;

   // First cycle out of hold only arms the timer, counting starts after
   always_ff @(posedge clock_40) begin
      if (reset_i || hold) begin
         timer_armed <= 1'b0;
         ready_cnt   <= '0;
      end else begin
         timer_armed <= 1'b1;
         if (timer_armed && (ready_cnt != ready_max))
            ready_cnt <= ready_cnt + 1'b1;       // Saturates at max
      end
   end

   assign ready_o = (ready_cnt == ready_max);

endmodule

// File: startup_sequencer.sv
`timescale 1ns/10ps

module startup_sequencer #(
   parameter int n_links        = 2,
   parameter int mgt_reset_step = startup_pkg::default_mgt_reset_step,
   parameter int txreset_cnt    = startup_pkg::default_txreset_cnt,
   parameter int done_cnt       = startup_pkg::default_done_cnt,
   parameter bit allow_retry    = 1'b0
) (
   input  logic               clock_40,
   input  logic               reset_i,
   input  logic               link_up_i,        // Registered transceiver done
   input  logic [n_links-1:0] mgt_reset_i,      // Manual per-link reset
   input  logic               txreset_i,        // Manual PCS reset
   output logic [n_links-1:0] mgt_reset_o,
   output logic               txreset_o,
   output logic               startup_done_o
);

   import startup_pkg::*;

   // ------------------------------------------------------------
   // Event thresholds
   // ------------------------------------------------------------

   localparam logic [startup_cnt_w-1:0] cnt_max = '1;   // Saturation value
   localparam logic [startup_cnt_w-1:0] txreset_at = startup_cnt_w'(txreset_cnt);
   localparam logic [startup_cnt_w-1:0] done_at = startup_cnt_w'(done_cnt);

   logic [startup_cnt_w-1:0] startup_cnt;   // Cycles since reset or retry
   logic                     startup_done;
   logic                     retry;

   // Link lost after a finished startup, run the whole sequence again
   assign retry = allow_retry && startup_done && !link_up_i;

   // ------------------------------------------------------------
   // Saturating startup counter
   // ------------------------------------------------------------

   always_ff @(posedge clock_40) begin
      if (reset_i || retry) begin
         startup_cnt <= '0;                    // 0 in first cycle out of reset
      end else if (startup_cnt != cnt_max) begin
         startup_cnt <= startup_cnt + 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Staggered link resets
   // ------------------------------------------------------------

   // Link k leaves reset at step*(k+1), so links come up one after another
   for (genvar k = 0; k < n_links; k++) begin : release_gen
      localparam logic [startup_cnt_w-1:0] release_at =
         startup_cnt_w'(mgt_reset_step * (k + 1));

      assign mgt_reset_o[k] = mgt_reset_i[k] || (startup_cnt < release_at);
   end

   // Single-cycle PCS reset, or held by the manual input
   assign txreset_o = txreset_i || (startup_cnt == txreset_at);

   assign startup_done   = (startup_cnt > done_at);   // Level, stays high until retry
   assign startup_done_o = startup_done;

endmodule

// File: startup_pkg.sv
package startup_pkg;

   // ------------------------------------------------------------
   // Startup counter, counted in clock_40 cycles
   // ------------------------------------------------------------

   localparam int startup_cnt_w = 22;   // Saturates after roughly 105 ms

   // Link reset releases are spaced 4 ms apart
   localparam int default_mgt_reset_step = 160000;

   // PCS reset pulse at 18 ms
   localparam int default_txreset_cnt = 720000;

   // Startup is complete at 30 ms
   localparam int default_done_cnt = 1200000;

endpackage

// File: gem_link_pkg.sv
package gem_link_pkg;

   // ------------------------------------------------------------
   // Link data geometry
   // ------------------------------------------------------------

   localparam int link_data_w = 56;   // GEM half-word carried by one link
   localparam int tx_word_w   = 16;   // Transceiver parallel word
   localparam int frame_words = 4;    // Words per 40 MHz frame

   // Separator K-codes, low byte of frame word 0
   typedef enum logic [7:0] {
      k28_0 = 8'h1C,   // BC0
      k28_1 = 8'h3C,   // Resync
      k30_7 = 8'hFE,   // Cluster overflow
      k28_5 = 8'hBC,   // Rotation, bunch counter lsbs 0
      k23_7 = 8'hF7,   // Rotation, lsbs 1
      k27_7 = 8'hFB,   // Rotation, lsbs 2
      k29_7 = 8'hFD    // Rotation, lsbs 3
   } kcode_t;

   // Position inside the frame
   typedef enum logic [$clog2(frame_words)-1:0] {
      word_sep, word_1, word_2, word_3
   } frame_word_t;

   localparam logic [tx_word_w-1:0] idle_word = 16'hFFFC;   // Sent while link is down

endpackage
